// ==== common/imul_pkg.sv ====
//--------------------------------------------------------------------
// iterative multiplier package
// shared widths, step count and controller state encoding
//--------------------------------------------------------------------

package imul_pkg;

  // operand and product widths
  localparam int imul_width      = 32;
  localparam int imul_prod_width = 2 * imul_width;

  // step counter
  // holds the number of steps left after the current one
  localparam int imul_cnt_width = 5;
  localparam int imul_last_step = imul_width - 1;

  // controller states
  typedef enum logic [1:0] {
    // waiting for a request
    st_idle = 2'd0,
    // shift-add steps in progress
    st_calc = 2'd1,
    // product held on the response port
    st_done = 2'd2
  } imul_state_e;

endpackage

// ==== imul/imul_counter.sv ====
//--------------------------------------------------------------------
// iterative multiplier step counter
// counts down the remaining shift-add steps and flags the final one
//--------------------------------------------------------------------

`timescale 1ns/1ps

module imul_counter
  import imul_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // from the controller
  input  logic load,
  input  logic step,

  // current step is the final one
  output logic last
);

  logic [imul_cnt_width-1:0] count;

  // steps left after the current one
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= imul_cnt_width'(imul_last_step);
    end else if (step) begin
      count <= count - 1'b1;
    end
  end

  // zero means this is the 32nd step
  assign last = (count == '0);

  // controller never loads and steps in the same cycle
  a_load_step_excl: assert property (@(posedge clk) disable iff (reset)
    !(load && step));

endmodule

// ==== imul/imul_dpath.sv ====
//--------------------------------------------------------------------
// iterative multiplier datapath
// magnitude conversion, shift-add accumulation and sign restoration
//--------------------------------------------------------------------

`timescale 1ns/1ps

module imul_dpath
  import imul_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,

  // request operands, captured on load
  input  logic signed [imul_width-1:0] req_a,
  input  logic signed [imul_width-1:0] req_b,

  // from the controller
  input  logic                        load,
  input  logic                        step,

  // signed product
  output logic [imul_prod_width-1:0]  resp_result
);

  //--------------------------------------------------------------------
  // operand magnitudes
  //--------------------------------------------------------------------

  logic [imul_width-1:0] mag_a;
  logic [imul_width-1:0] mag_b;
  logic                  sign_in;

  // two's-complement negate when the sign bit is set
  // most negative value maps to 2^31, still fits unsigned 32 bits
  assign mag_a = req_a[imul_width-1] ? (~req_a + 1'b1) : req_a;
  assign mag_b = req_b[imul_width-1] ? (~req_b + 1'b1) : req_b;

  // product is negative when exactly one operand is
  assign sign_in = req_a[imul_width-1] ^ req_b[imul_width-1];

  //--------------------------------------------------------------------
  // shift registers
  //--------------------------------------------------------------------

  // multiplicand shifts left, widened so no bits fall off
  logic [imul_prod_width-1:0] mcand;
  // multiplier shifts right, low bit picks the add
  logic [imul_width-1:0]      mplier;

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{imul_width{1'b0}}, mag_a};
      mplier <= mag_b;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  //--------------------------------------------------------------------
  // accumulator and result sign
  //--------------------------------------------------------------------

  logic [imul_prod_width-1:0] acc;
  logic [imul_prod_width-1:0] acc_next;
  logic                       sign;

  // add the current multiplicand only for a set multiplier bit
  assign acc_next = mplier[0] ? (acc + mcand) : acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc  <= '0;
      sign <= 1'b0;
    end else if (load) begin
      // fresh product starts from zero
      acc  <= '0;
      sign <= sign_in;
    end else if (step) begin
      acc  <= acc_next;
    end
  end

  //--------------------------------------------------------------------
  // sign restoration
  //--------------------------------------------------------------------

  // acc is stable in st_done, so the result holds under back-pressure
  assign resp_result = sign ? (~acc + 1'b1) : acc;

endmodule

// ==== imul/imul_ctrl.sv ====
//--------------------------------------------------------------------
// iterative multiplier controller
// sequences idle, calc and done and owns both val/rdy handshakes
//--------------------------------------------------------------------

`timescale 1ns/1ps

module imul_ctrl
  import imul_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // request handshake
  input  logic req_val,
  output logic req_rdy,

  // response handshake
  output logic resp_val,
  input  logic resp_rdy,

  // counter and datapath steering
  output logic load,
  output logic step,
  input  logic last
);

  imul_state_e state;
  imul_state_e state_next;

  //--------------------------------------------------------------------
  // outputs
  //--------------------------------------------------------------------

  // only one item in flight, so accept in idle only
  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // load is the request transfer itself
  assign load = req_rdy && req_val;
  // one shift-add step every calc cycle
  assign step = (state == st_calc);

  //--------------------------------------------------------------------
  // next state
  //--------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (load) begin
          state_next = st_calc;
        end
      end
      st_calc: begin
        // last step is taken in this cycle
        if (last) begin
          state_next = st_done;
        end
      end
      st_done: begin
        // response transfer frees the unit
        if (resp_rdy) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------

  // stalled response stays up and keeps the request side closed
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && !req_rdy);

  // captured operands start the shift-add steps on the next cycle
  a_load_calc: assert property (@(posedge clk) disable iff (reset)
    load |=> step && !req_rdy);

  // state register only ever holds one of the three encodings
  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {st_idle, st_calc, st_done});

endmodule

// ==== design/imul_top.sv ====
//--------------------------------------------------------------------
// iterative signed multiplier top level
// 32x32 to 64-bit product over 32 shift-add steps, val/rdy both sides
//--------------------------------------------------------------------

`timescale 1ns/1ps

module imul_top
  import imul_pkg::*;
(
  input  logic                         clk,
  input  logic                         reset,

  // request port
  input  logic signed [imul_width-1:0] req_a,
  input  logic signed [imul_width-1:0] req_b,
  input  logic                         req_val,
  output logic                         req_rdy,

  // response port
  output logic [imul_prod_width-1:0]   resp_result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  // steering from the controller
  logic load;
  logic step;
  // final step flag from the counter
  logic last;

  imul_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .step     (step),
    .last     (last)
  );

  imul_counter u_counter (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .step  (step),
    .last  (last)
  );

  imul_dpath u_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .step        (step),
    .resp_result (resp_result)
  );

endmodule

// ==== bench/tb_imul_ref.svh ====
//--------------------------------------------------------------------
// multiplier reference model and response check
//--------------------------------------------------------------------

`ifndef TB_IMUL_REF_SVH
`define TB_IMUL_REF_SVH

// signed product straight from the language's own multiply
function automatic logic [imul_prod_width-1:0] ref_mul(
  input logic signed [imul_width-1:0] a,
  input logic signed [imul_width-1:0] b
);
  logic signed [imul_prod_width-1:0] a_ext;
  logic signed [imul_prod_width-1:0] b_ext;
  logic signed [imul_prod_width-1:0] prod;
  // sign-extend both operands to the full product width
  a_ext = {{imul_width{a[imul_width-1]}}, a};
  b_ext = {{imul_width{b[imul_width-1]}}, b};
  prod  = a_ext * b_ext;
  return prod;
endfunction

// compare one transferred response with its expected product
task automatic check_response(
  input logic [imul_prod_width-1:0] got,
  input logic [imul_prod_width-1:0] expected
);
  if (got !== expected) begin
    error_count++;
    $display("Mismatch at %0t: resp_result got %h expected %h",
             $time, got, expected);
  end
endtask

// stalled response must not move
task automatic check_held(
  input logic [imul_prod_width-1:0] got,
  input logic [imul_prod_width-1:0] held
);
  if (got !== held) begin
    error_count++;
    $display("Mismatch at %0t: resp_result got %h expected %h during stall",
             $time, got, held);
  end
endtask

`endif

// ==== bench/tb_imul.sv ====
//--------------------------------------------------------------------
// iterative multiplier testbench
// directed and random products, latency, stalls and back-to-back
//--------------------------------------------------------------------

`timescale 1ns/1ps

module tb_imul
  import imul_pkg::*;
();

  localparam int num_ops     = 206;
  localparam int chain_from  = 106;
  localparam int cycle_limit = 12000;

  logic clk;
  logic reset;
  logic signed [imul_width-1:0] req_a;
  logic signed [imul_width-1:0] req_b;
  logic req_val;
  logic req_rdy;
  logic [imul_prod_width-1:0] resp_result;
  logic resp_val;
  logic resp_rdy;

  // outputs sampled mid low phase and stable until the next rising edge
  logic s_req_rdy;
  logic s_resp_val;
  logic [imul_prod_width-1:0] s_result;

  logic signed [imul_width-1:0] op_a [num_ops];
  logic signed [imul_width-1:0] op_b [num_ops];
  int stall_of [num_ops];
  logic [imul_prod_width-1:0] exp_q [$];
  int error_count;
  int sent_count;
  int accept_count;
  int check_count;
  int cycle_count;
  integer seed;
  imul_state_e want_state;

  `include "tb_imul_ref.svh"

  imul_top uut (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //--------------------------------------------------------------------
  // compare process acting on transfers at each rising edge
  //--------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (req_val && s_req_rdy) begin
        exp_q.push_back(ref_mul(req_a, req_b));
        accept_count++;
      end
      if (s_resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("response transferred with no request outstanding");
        end else begin
          check_response(s_result, exp_q.pop_front());
        end
        check_count++;
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      error_count++;
      $display("timeout, run did not finish within %0d cycles", cycle_limit);
      report_and_finish();
    end
  end

  task automatic report_and_finish();
    $display("errors: %0d  accepted: %0d  checked: %0d",
             error_count, accept_count, check_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // move to the next falling edge and sample the outputs there
  task automatic tick();
    @(negedge clk);
    s_req_rdy  = req_rdy;
    s_resp_val = resp_val;
    s_result   = resp_result;
  endtask

  task automatic run_one(input int idx, input bit chain);
    int n;
    logic [imul_prod_width-1:0] held;
    req_a    = op_a[idx];
    req_b    = op_b[idx];
    req_val  = 1'b1;
    resp_rdy = 1'b0;
    while (!s_req_rdy) tick();
    sent_count++;
    // acceptance edge comes next
    tick();
    req_val = 1'b0;
    n = 0;
    while (!s_resp_val && n < 40) begin
      if (s_req_rdy) begin
        error_count++;
        $display("req_rdy high at %0t while a product is in flight", $time);
      end
      tick();
      n++;
    end
    if (n != 32) begin
      error_count++;
      $display("resp_val did not rise 32 cycles after acceptance (%s after %0d)",
               want_state.name(), n);
    end
    held = s_result;
    repeat (stall_of[idx]) begin
      tick();
      if (!s_resp_val || s_req_rdy) begin
        error_count++;
        $display("handshake moved at %0t during a response stall", $time);
      end
      check_held(s_result, held);
    end
    resp_rdy = 1'b1;
    // next pair waits on the bus while the response goes out
    if (chain && idx + 1 < num_ops) begin
      req_a   = op_a[idx+1];
      req_b   = op_b[idx+1];
      req_val = 1'b1;
    end
    tick();
    resp_rdy = 1'b0;
    if (!s_req_rdy) begin
      error_count++;
      $display("req_rdy not high after the response transfer at %0t", $time);
    end
  endtask

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------

  initial begin
    reset = 1'b1;
    req_a = '0;
    req_b = '0;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    s_req_rdy = 1'b0;
    s_resp_val = 1'b0;
    s_result = '0;
    error_count = 0;
    sent_count = 0;
    accept_count = 0;
    check_count = 0;
    cycle_count = 0;
    seed = 97609;
    want_state = st_done;
    // corner pairs first and then random operands and stalls
    op_a[0] = 32'sd0;
    op_b[0] = 32'sh1234_5678;
    op_a[1] = 32'sd1;
    op_b[1] = -32'sd1;
    op_a[2] = -32'sd1;
    op_b[2] = -32'sd1;
    op_a[3] = 32'sh8000_0000;
    op_b[3] = 32'sh8000_0000;
    op_a[4] = 32'sh7fff_ffff;
    op_b[4] = 32'sh8000_0000;
    op_a[5] = -32'sd123456789;
    op_b[5] = 32'sd987654;
    for (int i = 0; i < num_ops; i++) begin
      if (i >= 6) begin
        op_a[i] = $random(seed);
        op_b[i] = $random(seed);
      end
      stall_of[i] = (i < 6) ? 0 : int'($unsigned($random(seed)) % 9);
    end
    repeat (5) tick();
    reset = 1'b0;
    tick();
    if (!s_req_rdy || s_resp_val) begin
      error_count++;
      $display("after reset req_rdy is not high or resp_val is not low");
    end
    for (int i = 0; i < num_ops; i++) begin
      run_one(i, i >= chain_from);
    end
    tick();
    tick();
    if (sent_count != accept_count || accept_count != check_count
        || exp_q.size() != 0) begin
      error_count++;
      $display("requests lost or taken twice, sent %0d accepted %0d checked %0d",
               sent_count, accept_count, check_count);
    end
    report_and_finish();
  end

endmodule

// ==== filelist.f ====
+incdir+bench
common/imul_pkg.sv
imul/imul_counter.sv
imul/imul_dpath.sv
imul/imul_ctrl.sv
design/imul_top.sv
bench/tb_imul.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the iterative multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_bin=tb_imul_sim

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_imul -f filelist.f -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Checks failed" "$log_file"; then
  exit 1
fi
if ! grep -q "All checks passed" "$log_file"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
